//--- hw/ibex_shell_pkg.sv
// Shared types and constants for the core-side shell
// Word and address types, register-file word with parity, alert group,
// scramble key defaults and the key manager state encoding
package ibex_shell_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  localparam int unsigned WORD_W      = 32;
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned SCR_KEY_W   = 128;
  localparam int unsigned SCR_NONCE_W = 64;

  // Register count for the full and the embedded base ISA
  localparam int unsigned RF_WORDS_I = 32;
  localparam int unsigned RF_WORDS_E = 16;
  localparam int unsigned RF_ADDR_W_E = 4;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  typedef logic [WORD_W-1:0]      word_t;
  typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
  typedef logic [SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [SCR_NONCE_W-1:0] scr_nonce_t;

  // Register-file word, parity is the XOR of all data bits
  typedef struct packed {
    word_t data;
    logic  parity;
  } rf_word_t;

  // Even parity of zero data is zero
  localparam rf_word_t RF_ZERO_WORD = '{data: '0, parity: 1'b0};

  // One alert group as raised by the core or the lockstep checker
  typedef struct packed {
    logic minor;
    logic major_internal;
    logic major_bus;
  } alerts_t;

  ////////////////////////////////////////////////////////////
  // Instruction cache scrambling
  ////////////////////////////////////////////////////////////

  // Values held until the first key arrives
  localparam scr_key_t SCR_KEY_DEFAULT =
    128'h3a9f_61c2_d804_7be5_915c_0f2a_e6b3_4d78;
  localparam scr_nonce_t SCR_NONCE_DEFAULT = 64'h7c15_a9e0_38d2_f64b;

  // Key manager states
  typedef enum logic [0:0] {
    SCR_KEY_VALID = 1'b0,
    SCR_KEY_REQ   = 1'b1
  } scr_state_e;

endpackage

//--- hw/core_status_ctrl.sv
// Core wake and sleep status plus alert merging
// The busy flag is registered, the debug and interrupt wakes are not
`timescale 1ns/1ps

module core_status_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    core_busy_i,
  input  logic                    debug_req_i,
  input  logic                    irq_pending_i,
  input  logic                    irq_nm_i,
  input  logic                    rf_err_i,
  input  ibex_shell_pkg::alerts_t core_alerts_i,
  input  ibex_shell_pkg::alerts_t lockstep_alerts_i,
  output logic                    core_sleep_o,
  output ibex_shell_pkg::alerts_t alerts_o
);

  logic core_busy_q;
  logic clock_en;

  ////////////////////////////////////////////////////////////
  // Wake logic
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Debug and interrupts wake the core without waiting a cycle
  assign clock_en = core_busy_q | debug_req_i | irq_pending_i | irq_nm_i;

  // Reported only, no clock is gated here
  assign core_sleep_o = ~clock_en;

  ////////////////////////////////////////////////////////////
  // Alert merging
  ////////////////////////////////////////////////////////////

  always_comb begin
    alerts_o.minor          = core_alerts_i.minor | lockstep_alerts_i.minor;
    // Register-file parity errors count as internal faults
    alerts_o.major_internal = core_alerts_i.major_internal |
                              lockstep_alerts_i.major_internal |
                              rf_err_i;
    alerts_o.major_bus      = core_alerts_i.major_bus | lockstep_alerts_i.major_bus;
  end

endmodule

//--- hw/scramble_key_ctrl.sv
// Instruction cache scrambling key manager
// Raises a key request on an icache invalidate and holds it until a new
// key and nonce arrive, which are stored for the cache RAMs
`timescale 1ns/1ps

module scramble_key_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       ic_scr_key_req_i,
  input  logic                       scramble_key_valid_i,
  input  ibex_shell_pkg::scr_key_t   scramble_key_i,
  input  ibex_shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                       scramble_req_o,
  output logic                       ic_scr_key_valid_o,
  output ibex_shell_pkg::scr_key_t   key_o,
  output ibex_shell_pkg::scr_nonce_t nonce_o
);

  ibex_shell_pkg::scr_state_e state_q;
  ibex_shell_pkg::scr_state_e state_d;

  ibex_shell_pkg::scr_key_t   key_q;
  ibex_shell_pkg::scr_nonce_t nonce_q;

  ////////////////////////////////////////////////////////////
  // Request FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ibex_shell_pkg::SCR_KEY_VALID: begin
        // Icache asks for a fresh key
        if (ic_scr_key_req_i) begin
          state_d = ibex_shell_pkg::SCR_KEY_REQ;
        end
      end
      ibex_shell_pkg::SCR_KEY_REQ: begin
        if (scramble_key_valid_i) begin
          state_d = ibex_shell_pkg::SCR_KEY_VALID;
        end
      end
      default: begin
        state_d = ibex_shell_pkg::SCR_KEY_VALID;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ibex_shell_pkg::SCR_KEY_VALID;
    end else begin
      state_q <= state_d;
    end
  end

  // Request stays up for as long as the key is missing
  assign scramble_req_o     = (state_q == ibex_shell_pkg::SCR_KEY_REQ);
  assign ic_scr_key_valid_o = (state_q == ibex_shell_pkg::SCR_KEY_VALID);

  ////////////////////////////////////////////////////////////
  // Key and nonce storage
  ////////////////////////////////////////////////////////////

  // Any strobe loads, requested or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= ibex_shell_pkg::SCR_KEY_DEFAULT;
      nonce_q <= ibex_shell_pkg::SCR_NONCE_DEFAULT;
    end else if (scramble_key_valid_i) begin
      key_q   <= scramble_key_i;
      nonce_q <= scramble_nonce_i;
    end
  end

  assign key_o   = key_q;
  assign nonce_o = nonce_q;

endmodule

//--- hw/reg_file_parity.sv
// Flop-based register file, two read ports and one write port
// Each word carries an even-parity bit which is checked on both reads
`timescale 1ns/1ps

module reg_file_parity #(
  parameter bit RV32E = 1'b0
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Read ports, combinational
  input  ibex_shell_pkg::reg_addr_t raddr_a_i,
  input  ibex_shell_pkg::reg_addr_t raddr_b_i,
  output ibex_shell_pkg::rf_word_t  rdata_a_o,
  output ibex_shell_pkg::rf_word_t  rdata_b_o,

  // Write port
  input  logic                      we_i,
  input  ibex_shell_pkg::reg_addr_t waddr_i,
  input  ibex_shell_pkg::rf_word_t  wdata_i,

  // Parity mismatch on either read port
  output logic                      err_o
);

  localparam int unsigned NUM_WORDS = RV32E ? ibex_shell_pkg::RF_WORDS_E :
                                              ibex_shell_pkg::RF_WORDS_I;
  // Embedded base ISA drops address bit 4
  localparam int unsigned ADDR_W = RV32E ? ibex_shell_pkg::RF_ADDR_W_E :
                                           ibex_shell_pkg::REG_ADDR_W;

  logic [NUM_WORDS-1:1]     we_dec;
  ibex_shell_pkg::rf_word_t rf_reg [NUM_WORDS];
  logic                     parity_err_a;
  logic                     parity_err_b;

  function automatic logic parity_bad(ibex_shell_pkg::rf_word_t word);
    return (^word.data) != word.parity;
  endfunction

  ////////////////////////////////////////////////////////////
  // Write decode and storage
  ////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 1; i < NUM_WORDS; i++) begin
      we_dec[i] = we_i && (waddr_i[ADDR_W-1:0] == ADDR_W'(i));
    end
  end

  // x0 has no storage, so writes to it are lost
  for (genvar i = 1; i < NUM_WORDS; i++) begin : gen_regs
    ibex_shell_pkg::rf_word_t reg_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        reg_q <= ibex_shell_pkg::RF_ZERO_WORD;
      end else if (we_dec[i]) begin
        reg_q <= wdata_i;
      end
    end

    assign rf_reg[i] = reg_q;
  end

  assign rf_reg[0] = ibex_shell_pkg::RF_ZERO_WORD;

  ////////////////////////////////////////////////////////////
  // Read ports and parity check
  ////////////////////////////////////////////////////////////

  assign rdata_a_o = rf_reg[raddr_a_i[ADDR_W-1:0]];
  assign rdata_b_o = rf_reg[raddr_b_i[ADDR_W-1:0]];

  // Checked on what leaves the array, so a corrupted write is caught on read
  assign parity_err_a = parity_bad(rdata_a_o);
  assign parity_err_b = parity_bad(rdata_b_o);

  assign err_o = parity_err_a | parity_err_b;

endmodule

//--- hw/ibex_shell_top.sv
// Core-side shell top level
// Sleep and alert logic, parity-checked register file and the icache
// scrambling key manager, with the core's signals brought out as ports
`timescale 1ns/1ps

module ibex_shell_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  // Wake sources and sleep status
  input  logic                      core_busy_i,
  input  logic                      debug_req_i,
  input  logic                      irq_pending_i,
  input  logic                      irq_nm_i,
  output logic                      core_sleep_o,

  // Register file, core side
  input  ibex_shell_pkg::reg_addr_t rf_raddr_a_i,
  input  ibex_shell_pkg::reg_addr_t rf_raddr_b_i,
  input  logic                      rf_we_i,
  input  ibex_shell_pkg::reg_addr_t rf_waddr_i,
  input  ibex_shell_pkg::rf_word_t  rf_wdata_i,
  output ibex_shell_pkg::rf_word_t  rf_rdata_a_o,
  output ibex_shell_pkg::rf_word_t  rf_rdata_b_o,

  // Alerts
  input  ibex_shell_pkg::alerts_t   core_alerts_i,
  input  ibex_shell_pkg::alerts_t   lockstep_alerts_i,
  output ibex_shell_pkg::alerts_t   alerts_o,

  // Scrambling key interface
  input  logic                      ic_scr_key_req_i,
  output logic                      ic_scr_key_valid_o,
  input  logic                      scramble_key_valid_i,
  input  ibex_shell_pkg::scr_key_t  scramble_key_i,
  input  ibex_shell_pkg::scr_nonce_t scramble_nonce_i,
  output logic                      scramble_req_o,
  output ibex_shell_pkg::scr_key_t  scr_key_o,
  output ibex_shell_pkg::scr_nonce_t scr_nonce_o
);

  // Parity error from the register file, feeds the major internal alert
  logic rf_err;

  ////////////////////////////////////////////////////////////
  // Sleep and alerts
  ////////////////////////////////////////////////////////////

  core_status_ctrl u_core_status_ctrl (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .core_busy_i      (core_busy_i),
    .debug_req_i      (debug_req_i),
    .irq_pending_i    (irq_pending_i),
    .irq_nm_i         (irq_nm_i),
    .rf_err_i         (rf_err),
    .core_alerts_i    (core_alerts_i),
    .lockstep_alerts_i(lockstep_alerts_i),
    .core_sleep_o     (core_sleep_o),
    .alerts_o         (alerts_o)
  );

  ////////////////////////////////////////////////////////////
  // Register file
  ////////////////////////////////////////////////////////////

  reg_file_parity #(
    .RV32E(1'b0)
  ) u_reg_file_parity (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(rf_raddr_a_i),
    .raddr_b_i(rf_raddr_b_i),
    .rdata_a_o(rf_rdata_a_o),
    .rdata_b_o(rf_rdata_b_o),
    .we_i     (rf_we_i),
    .waddr_i  (rf_waddr_i),
    .wdata_i  (rf_wdata_i),
    .err_o    (rf_err)
  );

  ////////////////////////////////////////////////////////////
  // Scrambling key manager
  ////////////////////////////////////////////////////////////

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .ic_scr_key_req_i    (ic_scr_key_req_i),
    .scramble_key_valid_i(scramble_key_valid_i),
    .scramble_key_i      (scramble_key_i),
    .scramble_nonce_i    (scramble_nonce_i),
    .scramble_req_o      (scramble_req_o),
    .ic_scr_key_valid_o  (ic_scr_key_valid_o),
    .key_o               (scr_key_o),
    .nonce_o             (scr_nonce_o)
  );

endmodule

//--- verification/tb_ibex_shell_checks.svh
// Compare tasks for the shell testbench, typed to the DUT's port types
// Included inside the testbench module, shares its error counters
`ifndef TB_IBEX_SHELL_CHECKS_SVH
`define TB_IBEX_SHELL_CHECKS_SVH

  // Value mismatches, then timeouts and late responses
  int unsigned mismatch_count = 0;
  int unsigned protocol_count = 0;

  task automatic check_word(input string name, input ibex_shell_pkg::rf_word_t act,
                            input ibex_shell_pkg::rf_word_t exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_alerts(input string name, input ibex_shell_pkg::alerts_t act,
                              input ibex_shell_pkg::alerts_t exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %b, expected %b", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_key(input string name, input ibex_shell_pkg::scr_key_t act,
                           input ibex_shell_pkg::scr_key_t exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_nonce(input string name, input ibex_shell_pkg::scr_nonce_t act,
                             input ibex_shell_pkg::scr_nonce_t exp);
    if (act !== exp) begin
      $display("mismatch at %0t: %s is %h, expected %h", $time, name, act, exp);
      mismatch_count++;
    end
  endtask

`endif

//--- verification/tb_ibex_shell_top.sv
// Testbench for the core-side shell
// Plays the core and the key source, then checks the register file, alert
// merging, sleep status and the icache scrambling key exchange
`timescale 1ns/1ps

module tb_ibex_shell_top;

  localparam int unsigned NUM_WRITES     = 16;
  localparam int unsigned NUM_ALERT_ROWS = 8;
  localparam int unsigned NUM_SLEEP_ROWS = 12;
  localparam int unsigned NUM_KEYS       = 3;
  localparam int unsigned WAIT_LIMIT     = 20;

  integer seed = 32'hc1e9_65ce;

  logic clk_i;
  logic rst_ni;
  logic core_busy_i;
  logic debug_req_i;
  logic irq_pending_i;
  logic irq_nm_i;
  logic core_sleep_o;
  logic rf_we_i;
  logic ic_scr_key_req_i;
  logic ic_scr_key_valid_o;
  logic scramble_key_valid_i;
  logic scramble_req_o;
  ibex_shell_pkg::reg_addr_t  rf_raddr_a_i;
  ibex_shell_pkg::reg_addr_t  rf_raddr_b_i;
  ibex_shell_pkg::reg_addr_t  rf_waddr_i;
  ibex_shell_pkg::rf_word_t   rf_wdata_i;
  ibex_shell_pkg::rf_word_t   rf_rdata_a_o;
  ibex_shell_pkg::rf_word_t   rf_rdata_b_o;
  ibex_shell_pkg::alerts_t    core_alerts_i;
  ibex_shell_pkg::alerts_t    lockstep_alerts_i;
  ibex_shell_pkg::alerts_t    alerts_o;
  ibex_shell_pkg::scr_key_t   scramble_key_i;
  ibex_shell_pkg::scr_key_t   scr_key_o;
  ibex_shell_pkg::scr_nonce_t scramble_nonce_i;
  ibex_shell_pkg::scr_nonce_t scr_nonce_o;

  // Expected register contents
  ibex_shell_pkg::rf_word_t   rf_model [32];
  ibex_shell_pkg::reg_addr_t  wr_addr_tab [NUM_WRITES];
  ibex_shell_pkg::word_t      wr_data_tab [NUM_WRITES];
  ibex_shell_pkg::scr_key_t   key_tab [NUM_KEYS];
  ibex_shell_pkg::scr_nonce_t nonce_tab [NUM_KEYS];

  // Core alerts, lockstep alerts, merged result
  logic [8:0] alert_tab [NUM_ALERT_ROWS] = '{
    9'b000_000_000, 9'b001_000_001, 9'b000_100_100, 9'b010_000_010,
    9'b011_110_111, 9'b100_001_101, 9'b111_111_111, 9'b000_010_010
  };

  // busy, debug, irq, nmi, sleep in the drive cycle, sleep one cycle later
  logic [5:0] sleep_tab [NUM_SLEEP_ROWS] = '{
    6'b0000_11, 6'b0100_00, 6'b0000_11, 6'b0010_00, 6'b0001_00, 6'b0000_11,
    6'b1000_10, 6'b1000_00, 6'b0000_01, 6'b1010_00, 6'b0000_01, 6'b0000_11
  };

  `include "tb_ibex_shell_checks.svh"

  // All port names match the testbench signals
  ibex_shell_top dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Even parity when good is set and flipped parity otherwise
  function automatic ibex_shell_pkg::rf_word_t build_rf_word(ibex_shell_pkg::word_t data,
                                                             logic good);
    ibex_shell_pkg::rf_word_t w;
    w.data   = data;
    w.parity = good ? ^data : ~^data;
    return w;
  endfunction

  task automatic write_word(input ibex_shell_pkg::reg_addr_t addr,
                            input ibex_shell_pkg::rf_word_t word);
    next_cycle();
    rf_we_i    = 1'b1;
    rf_waddr_i = addr;
    rf_wdata_i = word;
    if (addr != '0) begin
      rf_model[addr] = word;
    end
  endtask

  task automatic read_pair(input ibex_shell_pkg::reg_addr_t addr_a,
                           input ibex_shell_pkg::reg_addr_t addr_b,
                           input ibex_shell_pkg::alerts_t exp_alerts);
    next_cycle();
    rf_we_i      = 1'b0;
    rf_raddr_a_i = addr_a;
    rf_raddr_b_i = addr_b;
    #1;
    check_word("rf_rdata_a_o", rf_rdata_a_o, rf_model[addr_a]);
    check_word("rf_rdata_b_o", rf_rdata_b_o, rf_model[addr_b]);
    check_alerts("alerts_o", alerts_o, exp_alerts);
  endtask

  task automatic read_all_regs();
    ibex_shell_pkg::reg_addr_t addr;
    for (int i = 0; i < 32; i++) begin
      addr = ibex_shell_pkg::reg_addr_t'(i);
      read_pair(addr, ~addr, '0);
    end
  endtask

  // The level is due right away and a late one is reported as well
  task automatic wait_scramble_req(input logic want);
    int unsigned cycles;
    cycles = 0;
    while (scramble_req_o !== want && cycles < WAIT_LIMIT) begin
      next_cycle();
      cycles++;
    end
    if (scramble_req_o !== want) begin
      $display("Timeout at %0t: scramble_req_o never went to %0b", $time, want);
      protocol_count++;
    end else if (cycles != 0) begin
      $display("scramble_req_o went to %0b %0d cycles late at %0t", want, cycles, $time);
      protocol_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    ibex_shell_pkg::scr_key_t   exp_key;
    ibex_shell_pkg::scr_nonce_t exp_nonce;
    integer rnd;

    rst_ni = 1'b0;
    {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = '0;
    {rf_we_i, rf_raddr_a_i, rf_raddr_b_i, rf_waddr_i, rf_wdata_i} = '0;
    {core_alerts_i, lockstep_alerts_i} = '0;
    {ic_scr_key_req_i, scramble_key_valid_i, scramble_key_i, scramble_nonce_i} = '0;
    for (int i = 0; i < 32; i++) begin
      rf_model[i] = ibex_shell_pkg::RF_ZERO_WORD;
    end
    for (int i = 0; i < NUM_WRITES; i++) begin
      rnd = $random(seed);
      wr_addr_tab[i] = rnd[4:0];
      if (i % 5 == 4) begin
        wr_addr_tab[i] = '0;
      end else if (wr_addr_tab[i] == '0) begin
        wr_addr_tab[i] = 5'd1;
      end
      wr_data_tab[i] = $random(seed);
    end
    for (int i = 0; i < NUM_KEYS; i++) begin
      key_tab[i]   = {$random(seed), $random(seed), $random(seed), $random(seed)};
      nonce_tab[i] = {$random(seed), $random(seed)};
    end
    repeat (5) @(posedge clk_i);
    #1 rst_ni = 1'b1;

    // Reset values
    check_bit("scramble_req_o", scramble_req_o, 1'b0);
    check_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b1);
    check_key("scr_key_o", scr_key_o, ibex_shell_pkg::SCR_KEY_DEFAULT);
    check_nonce("scr_nonce_o", scr_nonce_o, ibex_shell_pkg::SCR_NONCE_DEFAULT);
    read_all_regs();

    // Good parity writes read back on both ports
    for (int i = 0; i < NUM_WRITES; i++) begin
      write_word(wr_addr_tab[i], build_rf_word(wr_data_tab[i], 1'b1));
      read_pair(wr_addr_tab[i], wr_addr_tab[i], '0);
    end
    read_all_regs();

    // Corrupted parity shows on either read port
    write_word(5'd9, build_rf_word($random(seed), 1'b0));
    read_pair(5'd9, 5'd0, ibex_shell_pkg::alerts_t'(3'b010));
    read_pair(5'd0, 5'd9, ibex_shell_pkg::alerts_t'(3'b010));
    read_pair(5'd0, 5'd0, '0);

    for (int i = 0; i < NUM_ALERT_ROWS; i++) begin
      next_cycle();
      core_alerts_i     = ibex_shell_pkg::alerts_t'(alert_tab[i][8:6]);
      lockstep_alerts_i = ibex_shell_pkg::alerts_t'(alert_tab[i][5:3]);
      #1;
      check_alerts("alerts_o", alerts_o, ibex_shell_pkg::alerts_t'(alert_tab[i][2:0]));
    end
    {core_alerts_i, lockstep_alerts_i} = '0;

    for (int i = 0; i < NUM_SLEEP_ROWS; i++) begin
      next_cycle();
      {core_busy_i, debug_req_i, irq_pending_i, irq_nm_i} = sleep_tab[i][5:2];
      #1;
      check_bit("core_sleep_o", core_sleep_o, sleep_tab[i][1]);
      next_cycle();
      check_bit("core_sleep_o", core_sleep_o, sleep_tab[i][0]);
    end

    // Key exchange rounds
    exp_key   = ibex_shell_pkg::SCR_KEY_DEFAULT;
    exp_nonce = ibex_shell_pkg::SCR_NONCE_DEFAULT;
    for (int i = 0; i < NUM_KEYS; i++) begin
      next_cycle();
      ic_scr_key_req_i = 1'b1;
      #1;
      // Request only shows after the clock edge
      check_bit("scramble_req_o", scramble_req_o, 1'b0);
      check_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b1);
      next_cycle();
      ic_scr_key_req_i = 1'b0;
      wait_scramble_req(1'b1);
      check_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b0);
      repeat (3) begin
        next_cycle();
        check_bit("scramble_req_o", scramble_req_o, 1'b1);
        check_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b0);
        check_key("scr_key_o", scr_key_o, exp_key);
        check_nonce("scr_nonce_o", scr_nonce_o, exp_nonce);
      end
      next_cycle();
      scramble_key_valid_i = 1'b1;
      scramble_key_i       = key_tab[i];
      scramble_nonce_i     = nonce_tab[i];
      #1;
      // Old key and pending request until the strobe edge
      check_bit("scramble_req_o", scramble_req_o, 1'b1);
      check_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b0);
      check_key("scr_key_o", scr_key_o, exp_key);
      check_nonce("scr_nonce_o", scr_nonce_o, exp_nonce);
      exp_key              = key_tab[i];
      exp_nonce            = nonce_tab[i];
      next_cycle();
      scramble_key_valid_i = 1'b0;
      wait_scramble_req(1'b0);
      check_bit("ic_scr_key_valid_o", ic_scr_key_valid_o, 1'b1);
      check_key("scr_key_o", scr_key_o, exp_key);
      check_nonce("scr_nonce_o", scr_nonce_o, exp_nonce);
    end

    $display("Errors: %0d mismatches, %0d protocol failures", mismatch_count, protocol_count);
    if (mismatch_count == 0 && protocol_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- ibex_shell_top.f
+incdir+verification
hw/ibex_shell_pkg.sv
hw/core_status_ctrl.sv
hw/scramble_key_ctrl.sv
hw/reg_file_parity.sv
hw/ibex_shell_top.sv
verification/tb_ibex_shell_top.sv

//--- Makefile
# Verilator build and run for the core-side shell testbench

VERILATOR ?= verilator
TOP       ?= tb_ibex_shell_top
FILELIST  ?= ibex_shell_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= Simulation passed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verification/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the simulation output
run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
